//--- filelist.f
+incdir+.
fetch_pkg.sv
sync_queue.sv
two_bit_predictor.sv
jal_predecode.sv
inst_fetch.sv
fetch_top.sv
tb_clock.sv
tb_fetch_asserts.sv
tb_fetch.sv

//--- tb_fetch.sv
`include "fetch_cfg.svh"

module tb_fetch
    import fetch_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int WAIT_LIMIT = 2000;

    logic         clk;
    logic         arst_n;
    mem_req_t     mem_req;
    logic         mem_ready;
    mem_resp_t    mem_resp;
    redirect_t    redirect;
    bp_update_t   bp_update;
    fetch_entry_t fetch_out;
    logic         fetch_valid;
    logic         fetch_ready;

    // pending memory responses in request order
    logic [31:0]  pend_addr [$];
    int           pend_due [$];
    int           edge_cnt;
    int           delivered;
    int           timeouts;
    int           fails;
    logic         hold_ready_low;
    redirect_t    redirect_next;
    bp_update_t   update_next;

    tb_clock tb_clock_inst (
        .clk   (clk),
        .arst_n(arst_n)
    );

    fetch_top fetch_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_resp   (mem_resp),
        .redirect   (redirect),
        .bp_update  (bp_update),
        .fetch_out  (fetch_out),
        .fetch_valid(fetch_valid),
        .fetch_ready(fetch_ready)
    );

    // jal x0,+0x30 / beq x0,x0,+0x34 / jal x0,-0x20 / jal x0,-0xc0
    // addi x0 nop everywhere else
    function automatic logic [31:0] program_word(input logic [31:0] addr);
        logic [11:0] tag;
        tag = addr[13:2] ^ addr[25:14] ^ {6'b0, addr[31:26]};
        case (addr)
            32'h0000_0010: program_word = 32'h0300_006f;
            32'h0000_004c: program_word = 32'h0200_0a63;
            32'h0000_0060: program_word = 32'hfe1f_f06f;
            32'h0000_0100: program_word = 32'hf41f_f06f;
            default:       program_word = {tag, 20'h0_0013};
        endcase
    endfunction

    // one clock edge of memory, consumer and pulse stimulus
    task automatic step();
        int due;
        @(posedge clk);
        edge_cnt++;
        if (arst_n && fetch_valid && fetch_ready) begin
            delivered++;
        end
        if (arst_n && mem_req.valid && mem_ready) begin
            due = edge_cnt + int'($urandom_range(2, 0));
            if (pend_due.size() > 0 && due <= pend_due[$]) begin
                due = pend_due[$] + 1;
            end
            pend_addr.push_back(mem_req.addr);
            pend_due.push_back(due);
        end
        if (pend_due.size() > 0 && pend_due[0] <= edge_cnt) begin
            mem_resp <= '{valid: 1'b1, addr: pend_addr[0], inst: program_word(pend_addr[0])};
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end else begin
            mem_resp <= '0;
        end
        mem_ready   <= ($urandom_range(3, 0) != 0);
        fetch_ready <= hold_ready_low ? 1'b0 : ($urandom_range(9, 0) < 7);
        redirect    <= redirect_next;
        bp_update   <= update_next;
        redirect_next = '0;
        update_next   = '0;
    endtask

    task automatic wait_deliveries(input int count);
        int target;
        int n;
        target = delivered + count;
        n = 0;
        while (delivered < target && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (delivered < target) begin
            timeouts++;
            $display("timeout: %0d entries were never delivered", target - delivered);
        end
    endtask

    // stalls the consumer until the queue has no room left
    task automatic fill_queue();
        int n;
        hold_ready_low = 1'b1;
        n = 0;
        while (fetch_top_inst.inst_fetch_inst.sync_queue_inst.wready && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (fetch_top_inst.inst_fetch_inst.sync_queue_inst.wready) begin
            timeouts++;
            $display("timeout: the instruction queue never filled up");
        end
        repeat (4) step();
    endtask

    task automatic send_redirect(input logic [31:0] addr, input logic train);
        redirect_next = '{valid: 1'b1, addr: addr};
        if (train) begin
            update_next = '{valid: 1'b1, pc: 32'h4c, is_br: 1'b1, is_jmp: 1'b0,
                            taken: 1'b1, target: 32'h80};
        end
        step();
    endtask

    initial begin
        int n;
        void'($urandom(32'h20de));
        mem_ready      = 1'b0;
        mem_resp       = '0;
        redirect       = '0;
        bp_update      = '0;
        fetch_ready    = 1'b0;
        hold_ready_low = 1'b0;
        redirect_next  = '0;
        update_next    = '0;
        edge_cnt       = 0;
        delivered      = 0;
        timeouts       = 0;

        n = 0;
        while (!arst_n && n < 20) begin
            step();
            n++;
        end
        if (!arst_n) begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        // through the jal at 0x10 and around the 0x40 loop
        wait_deliveries(40);
        fill_queue();
        hold_ready_low = 1'b0;
        wait_deliveries(20);

        // train the loop branch while the pipe is flushed
        send_redirect(32'h40, 1'b1);
        wait_deliveries(50);

        // redirect straight into a full queue
        fill_queue();
        send_redirect(32'h08, 1'b0);
        hold_ready_low = 1'b0;
        wait_deliveries(30);

        repeat ($urandom_range(6, 1)) step();
        send_redirect(32'h60, 1'b0);
        repeat ($urandom_range(6, 1)) step();
        send_redirect(32'h200, 1'b0);
        wait_deliveries(20);

        fails = fetch_top_inst.tb_fetch_asserts_inst.fail_count;
        $display("closing report: %0d entries delivered, %0d assertion failures, %0d timeouts",
                 delivered, fails, timeouts);
        if (fails == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tb_fetch_asserts.sv
`include "fetch_cfg.svh"

module tb_fetch_asserts
    import fetch_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input mem_req_t     mem_req,
    input logic         mem_ready,
    input redirect_t    redirect,
    input bp_update_t   bp_update,
    input fetch_entry_t fetch_out,
    input logic         fetch_valid,
    input logic         fetch_ready,
    input logic         queue_wready
);
    timeunit 1ns;
    timeprecision 1ns;

    int          fail_count = 0;
    logic        xfer;
    logic        have_prev;
    logic [31:0] prev_addr;
    logic [31:0] first_addr;
    logic [31:0] exp_next;
    logic        trained;
    logic [31:0] trained_pc;
    logic [31:0] trained_target;
    fetch_id_t   issue_id;
    logic [31:0] issued_addr [2 ** `FETCH_ID_W];

    // test program with an addi x0 nop tagged by its address at any other word
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [11:0] tag;
        tag = addr[13:2] ^ addr[25:14] ^ {6'b0, addr[31:26]};
        case (addr)
            32'h0000_0010: expected_word = 32'h0300_006f;
            32'h0000_004c: expected_word = 32'h0200_0a63;
            32'h0000_0060: expected_word = 32'hfe1f_f06f;
            32'h0000_0100: expected_word = 32'hf41f_f06f;
            default:       expected_word = {tag, 20'h0_0013};
        endcase
    endfunction

    // transfers in a redirect cycle belong to the flushed stream
    assign xfer = fetch_valid && fetch_ready && !redirect.valid;

    always_comb begin
        case (prev_addr)
            32'h0000_0010: exp_next = prev_addr + 32'h30;
            32'h0000_0060: exp_next = prev_addr - 32'h20;
            32'h0000_0100: exp_next = prev_addr - 32'hc0;
            default:       exp_next = prev_addr + 32'd4;
        endcase
        if (trained && (prev_addr == trained_pc)) begin
            exp_next = trained_target;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            have_prev  <= 1'b0;
            prev_addr  <= '0;
            first_addr <= `FETCH_RESET_PC;
            trained    <= 1'b0;
            issue_id   <= '0;
        end else begin
            if (redirect.valid) begin
                have_prev  <= 1'b0;
                first_addr <= redirect.addr;
            end else if (xfer) begin
                have_prev <= 1'b1;
                prev_addr <= fetch_out.addr;
            end
            if (bp_update.valid && (bp_update.is_br || bp_update.is_jmp)) begin
                trained        <= bp_update.taken;
                trained_pc     <= bp_update.pc;
                trained_target <= bp_update.target;
            end
            if (mem_req.valid && mem_ready) begin
                issue_id <= issue_id + 1'b1;
            end
        end
    end

    // address of each accepted request by the id it was given
    always_ff @(posedge clk) begin
        if (arst_n && mem_req.valid && mem_ready) begin
            issued_addr[issue_id] <= mem_req.addr;
        end
    end

    first_entry: assert property (@(posedge clk) disable iff (!arst_n)
        xfer && !have_prev |-> fetch_out.addr == first_addr)
        else begin
            fail_count++;
            $error("ERR first_entry expected %h actual %h",
                   $sampled(first_addr), $sampled(fetch_out.addr));
        end

    next_entry: assert property (@(posedge clk) disable iff (!arst_n)
        xfer && have_prev |-> fetch_out.addr == exp_next)
        else begin
            fail_count++;
            $error("ERR next_entry expected %h actual %h",
                   $sampled(exp_next), $sampled(fetch_out.addr));
        end

    entry_word: assert property (@(posedge clk) disable iff (!arst_n)
        xfer |-> fetch_out.inst == expected_word(fetch_out.addr))
        else begin
            fail_count++;
            $error("ERR entry_word expected %h actual %h",
                   expected_word($sampled(fetch_out.addr)), $sampled(fetch_out.inst));
        end

    entry_id: assert property (@(posedge clk) disable iff (!arst_n)
        xfer |-> issued_addr[fetch_out.id] == fetch_out.addr)
        else begin
            fail_count++;
            $error("ERR entry_id id %0d expected addr %h actual addr %h",
                   $sampled(fetch_out.id), issued_addr[$sampled(fetch_out.id)],
                   $sampled(fetch_out.addr));
        end

    redirect_addr: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.valid |=> mem_req.addr == first_addr)
        else begin
            fail_count++;
            $error("ERR redirect_addr expected %h actual %h",
                   $sampled(first_addr), $sampled(mem_req.addr));
        end

    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_valid && !fetch_ready && !redirect.valid |=> fetch_valid && $stable(fetch_out))
        else begin
            fail_count++;
            $error("fetch output changed while the consumer was stalling");
        end

    full_no_request: assert property (@(posedge clk) disable iff (!arst_n)
        !queue_wready && !fetch_ready |-> !mem_req.valid)
        else begin
            fail_count++;
            $error("memory request raised while the queue was full and stalled");
        end

endmodule

bind fetch_top tb_fetch_asserts tb_fetch_asserts_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .mem_req     (mem_req),
    .mem_ready   (mem_ready),
    .redirect    (redirect),
    .bp_update   (bp_update),
    .fetch_out   (fetch_out),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .queue_wready(inst_fetch_inst.sync_queue_inst.wready)
);

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset low over the first four rising edges
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- fetch_top.sv
module fetch_top
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    output mem_req_t     mem_req,
    input  logic         mem_ready,
    input  mem_resp_t    mem_resp,
    input  redirect_t    redirect,
    input  bp_update_t   bp_update,
    output fetch_entry_t fetch_out,
    output logic         fetch_valid,
    input  logic         fetch_ready
);

    // fetch stage between instruction memory and decode
    inst_fetch inst_fetch_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .mem_ready  (mem_ready),
        .mem_resp   (mem_resp),
        .redirect   (redirect),
        .bp_update  (bp_update),
        .fetch_out  (fetch_out),
        .fetch_valid(fetch_valid),
        .fetch_ready(fetch_ready)
    );

endmodule

//--- inst_fetch.sv
`include "fetch_cfg.svh"

module inst_fetch
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    output mem_req_t     mem_req,
    input  logic         mem_ready,
    input  mem_resp_t    mem_resp,
    input  redirect_t    redirect,
    input  bp_update_t   bp_update,
    output fetch_entry_t fetch_out,
    output logic         fetch_valid,
    input  logic         fetch_ready
);

    localparam logic [31:0] INVALID_WORD = 32'hffff_ffff;

    logic [31:0] pc;
    logic        outstanding;
    logic [31:0] request_addr;
    fetch_id_t   next_id;
    logic [31:0] last_pc;
    logic [31:0] last_inst;

    logic         is_jal;
    logic         is_ctrl;
    logic [31:0]  jal_target;
    logic         jal_redirect;
    logic [31:0]  pred_base;
    logic [31:0]  pred_next_pc;
    logic [31:0]  next_pc;

    logic         resp_hit;
    logic         can_issue;
    logic         issue;
    logic         q_wvalid;
    logic         q_wready;
    logic         q_wready_next;
    fetch_entry_t q_wdata;

    jal_predecode jal_predecode_inst (
        .last_pc   (last_pc),
        .last_inst (last_inst),
        .is_jal    (is_jal),
        .is_ctrl   (is_ctrl),
        .jal_target(jal_target)
    );

    // jal not yet followed, the outstanding request is on the wrong path
    assign jal_redirect = is_jal && !is_ctrl && !(outstanding && (request_addr == jal_target));

    assign pred_base = redirect.valid ? redirect.addr :
                       jal_redirect   ? jal_target    :
                                        pc;

    two_bit_predictor #(
        .INDEX_W(`FETCH_BP_INDEX_W)
    ) two_bit_predictor_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .pc     (pred_base),
        .next_pc(pred_next_pc),
        .update (bp_update)
    );

    assign next_pc = jal_redirect ? jal_target + 32'd4 : pred_next_pc;

    // response for the single outstanding request
    assign resp_hit  = outstanding && mem_resp.valid && (mem_resp.addr == request_addr);
    assign can_issue = !outstanding || resp_hit;

    always_comb begin
        mem_req.valid = q_wready_next && can_issue && !redirect.valid;
        mem_req.addr  = jal_redirect ? jal_target : pc;
    end

    assign issue = mem_req.valid && mem_ready;

    // wrong-path words are dropped here
    assign q_wvalid = resp_hit && !jal_redirect && !redirect.valid;

    always_comb begin
        q_wdata.addr = request_addr;
        q_wdata.inst = mem_resp.inst;
        q_wdata.id   = next_id - 1'b1;
    end

    sync_queue #(
        .payload_t(fetch_entry_t),
        .DEPTH    (`FETCH_QUEUE_DEPTH)
    ) sync_queue_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (redirect.valid),
        .wvalid     (q_wvalid),
        .wdata      (q_wdata),
        .wready     (q_wready),
        .wready_next(q_wready_next),
        .rvalid     (fetch_valid),
        .rready     (fetch_ready),
        .rdata      (fetch_out)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= `FETCH_RESET_PC;
            outstanding  <= 1'b0;
            request_addr <= '0;
            next_id      <= '0;
            last_pc      <= INVALID_WORD;
            last_inst    <= INVALID_WORD;
        end else if (redirect.valid) begin
            pc          <= redirect.addr;
            outstanding <= 1'b0;
            last_pc     <= INVALID_WORD;
            last_inst   <= INVALID_WORD;
        end else begin
            // q_wready is always high here since issue waits for room
            if (q_wvalid && q_wready) begin
                last_pc   <= mem_resp.addr;
                last_inst <= mem_resp.inst;
            end
            if (issue) begin
                outstanding  <= 1'b1;
                request_addr <= mem_req.addr;
                pc           <= next_pc;
                next_id      <= next_id + 1'b1;
            end else begin
                if (resp_hit || jal_redirect) begin
                    outstanding <= 1'b0;
                end
                if (jal_redirect) begin
                    pc <= jal_target;
                end
            end
        end
    end

endmodule

//--- jal_predecode.sv
module jal_predecode
    import fetch_pkg::*;
(
    input  logic [31:0] last_pc,
    input  logic [31:0] last_inst,
    output logic        is_jal,
    output logic        is_ctrl,
    output logic [31:0] jal_target
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [19:0] imm_j;
    logic [31:0] imm_j_sext;

    assign opcode = last_inst[6:0];
    assign funct3 = last_inst[14:12];

    // j-type immediate, bit 0 is implied zero
    assign imm_j = {last_inst[31], last_inst[19:12], last_inst[20], last_inst[30:21]};
    assign imm_j_sext = {{11{imm_j[19]}}, imm_j, 1'b0};

    assign is_jal     = (opcode == jal_op);
    assign jal_target = last_pc + imm_j_sext;

    // targets of these come from the predictor
    assign is_ctrl = (opcode == br_op) || ((opcode == jalr_op) && (funct3 == 3'b000));

endmodule

//--- two_bit_predictor.sv
`include "fetch_cfg.svh"

module two_bit_predictor
    import fetch_pkg::*;
#(
    parameter int INDEX_W = `FETCH_BP_INDEX_W
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] pc,
    output logic [31:0] next_pc,
    input  bp_update_t  update
);

    localparam int ENTRIES = 2 ** INDEX_W;
    localparam int TAG_W   = 30 - INDEX_W;
    localparam logic [1:0] WEAK_NT = 2'b01;

    typedef struct packed {
        logic       valid;
        logic [1:0] cnt;
    } state_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      target;
    } entry_t;

    state_t state_q [ENTRIES];
    entry_t entry_q [ENTRIES];

    logic [INDEX_W-1:0] rd_idx;
    logic [TAG_W-1:0]   rd_tag;
    logic               rd_hit;

    logic [INDEX_W-1:0] wr_idx;
    logic [TAG_W-1:0]   wr_tag;
    logic               wr_hit;
    logic               train;
    logic [1:0]         wr_base;
    logic [1:0]         wr_cnt;

    // lookup, word aligned index with the rest of the pc as tag
    assign rd_idx = pc[INDEX_W+1:2];
    assign rd_tag = pc[31:INDEX_W+2];
    assign rd_hit = state_q[rd_idx].valid && (entry_q[rd_idx].tag == rd_tag);

    // counter msb set means 2 or 3, predict taken
    assign next_pc = (rd_hit && state_q[rd_idx].cnt[1]) ? entry_q[rd_idx].target
                                                         : pc + 32'd4;

    assign wr_idx = update.pc[INDEX_W+1:2];
    assign wr_tag = update.pc[31:INDEX_W+2];
    assign wr_hit = state_q[wr_idx].valid && (entry_q[wr_idx].tag == wr_tag);
    assign train  = update.valid && (update.is_br || update.is_jmp);

    // a fresh or replaced entry starts weakly not taken
    always_comb begin
        wr_base = wr_hit ? state_q[wr_idx].cnt : WEAK_NT;
        if (update.taken) begin
            wr_cnt = (wr_base == 2'b11) ? 2'b11 : wr_base + 2'b01;
        end else begin
            wr_cnt = (wr_base == 2'b00) ? 2'b00 : wr_base - 2'b01;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                state_q[i] <= '{valid: 1'b0, cnt: WEAK_NT};
            end
        end else if (train) begin
            state_q[wr_idx] <= '{valid: 1'b1, cnt: wr_cnt};
        end
    end

    always_ff @(posedge clk) begin
        if (train) begin
            entry_q[wr_idx] <= '{tag: wr_tag, target: update.target};
        end
    end

endmodule

//--- sync_queue.sv
`include "fetch_cfg.svh"

module sync_queue
    import fetch_pkg::*;
#(
    parameter type payload_t = fetch_entry_t,
    parameter int  DEPTH     = `FETCH_QUEUE_DEPTH
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     wvalid,
    input  payload_t wdata,
    output logic     wready,
    output logic     wready_next,
    output logic     rvalid,
    input  logic     rready,
    output payload_t rdata
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    assign wready = (count != FULL_CNT);
    assign rvalid = (count != '0);
    assign rdata  = mem[rd_ptr];

    assign push = wvalid && wready;
    assign pop  = rvalid && rready;

    // occupancy after this cycle's push and pop
    always_comb begin
        count_next = count;
        if (flush) begin
            count_next = '0;
        end else if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    assign wready_next = (count_next != FULL_CNT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            count <= count_next;
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
                end
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

//--- fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

    // rv32i major opcodes seen by the predecoder
    localparam logic [6:0] jal_op  = 7'b1101111;
    localparam logic [6:0] jalr_op = 7'b1100111;
    localparam logic [6:0] br_op   = 7'b1100011;

    // sequence number given to a request when it issues
    typedef logic [`FETCH_ID_W-1:0] fetch_id_t;

    // instruction memory request
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } mem_req_t;

    // instruction memory response, valid for one cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] inst;
    } mem_resp_t;

    // one instruction queue entry
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] inst;
        fetch_id_t   id;
    } fetch_entry_t;

    // back-end redirect pulse
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } redirect_t;

    // predictor training pulse from execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        is_br;
        logic        is_jmp;
        logic        taken;
        logic [31:0] target;
    } bp_update_t;

endpackage

//--- fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc loaded on reset
`define FETCH_RESET_PC 32'h0000_0000

// instruction queue entries
`define FETCH_QUEUE_DEPTH 8

// predictor table has 2**FETCH_BP_INDEX_W entries
`define FETCH_BP_INDEX_W 6

// width of the per-request sequence number
`define FETCH_ID_W 8

`endif
